//--- fp_multiplier_pkg.sv
package fp_multiplier_pkg;

	// Operation code, a plain level from the decode stage
	typedef logic [5:0] opcode_t;

	// Float multiply
	localparam opcode_t OP_FMUL = 6'h22;
	// Signed integer to float, done as a multiply by 1.0
	localparam opcode_t OP_ITOF = 6'h2a;

	// Biased exponent of a single-precision value
	typedef logic [7:0] exponent_t;

	// Multiplier input
	// Fraction with its hidden bit, or an integer magnitude
	typedef logic [31:0] significand_t;

	// Full unsigned product of two significands
	typedef logic [63:0] product_t;

	// Single-precision word
	// Also carries the two's complement integer operand
	typedef struct packed
	{
		logic sign;
		exponent_t exponent;
		logic [22:0] fraction;
	} float_t;

	// Registered output of the exponent path
	typedef struct packed
	{
		// Result sign
		logic sign;
		// Re-biased result exponent, before normalization
		exponent_t exponent;
		// Two's complement sum of the unbiased exponents wrapped
		logic exponent_overflow;
	} mul_stage1_t;

endpackage

//--- fp_multiplier_stage1.sv
module fp_multiplier_stage1
(
	input logic clk,
	input logic reset,
	input fp_multiplier_pkg::opcode_t operation,
	input fp_multiplier_pkg::float_t operand1,
	input fp_multiplier_pkg::float_t operand2,
	output fp_multiplier_pkg::significand_t multiplicand,
	output fp_multiplier_pkg::significand_t multiplier,
	output fp_multiplier_pkg::mul_stage1_t stage1
);
	import fp_multiplier_pkg::*;

	// Per-operand sign and biased exponent after operation select
	logic sign1;
	logic sign2;
	exponent_t exponent1;
	exponent_t exponent2;

	// Integer operand seen as a raw vector
	significand_t integer_raw;

	// Exponents in two's complement form
	exponent_t unbiased_exponent1;
	exponent_t unbiased_exponent2;
	exponent_t unbiased_sum;
	exponent_t result_exponent;
	logic result_sign;
	logic exponent_overflow;

	assign integer_raw = operand2;

	// First operand
	always_comb
	begin
		if (operation == OP_ITOF)
		begin
			// Stand-in 1.0 with the exponent equal to the bias
			sign1 = 1'b0;
			exponent1 = 8'd127;
			multiplicand = {8'd0, 1'b1, 23'd0};
		end
		else
		begin
			sign1 = operand1.sign;
			exponent1 = operand1.exponent;
			// Zero exponent gives a zero significand so denormals flush
			if (operand1.exponent == 8'd0)
				multiplicand = '0;
			else
				multiplicand = {8'd0, 1'b1, operand1.fraction};
		end
	end

	// Second operand
	always_comb
	begin
		if (operation == OP_ITOF)
		begin
			sign2 = integer_raw[31];
			// Integer value sits 23 places above the binary point
			exponent2 = 8'd150;
			// Magnitude of the integer
			// The most negative value still fits as unsigned
			if (integer_raw[31])
				multiplier = ~integer_raw + 32'd1;
			else
				multiplier = integer_raw;
		end
		else
		begin
			sign2 = operand2.sign;
			exponent2 = operand2.exponent;
			if (operand2.exponent == 8'd0)
				multiplier = '0;
			else
				multiplier = {8'd0, 1'b1, operand2.fraction};
		end
	end

	assign result_sign = sign1 ^ sign2;

	// Remove the bias of 127
	// Flipping the top bit subtracts 128 and the increment adds one back
	assign unbiased_exponent1 = {~exponent1[7], exponent1[6:0]} + 8'd1;
	assign unbiased_exponent2 = {~exponent2[7], exponent2[6:0]} + 8'd1;

	// Product exponent is the sum
	assign unbiased_sum = unbiased_exponent1 + unbiased_exponent2;

	// Same input signs but a different sum sign means the add wrapped
	assign exponent_overflow = (unbiased_exponent1[7] == unbiased_exponent2[7])
		&& (unbiased_sum[7] != unbiased_exponent1[7]);

	// Put the bias back
	assign result_exponent = {~unbiased_sum[7], unbiased_sum[6:0]} - 8'd1;

	// Sign, exponent and overflow travel together to the normalizer
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			stage1 <= '0;
		end
		else
		begin
			stage1.sign <= result_sign;
			stage1.exponent <= result_exponent;
			stage1.exponent_overflow <= exponent_overflow;
		end
	end

endmodule

//--- fp_significand_multiplier.sv
module fp_significand_multiplier
(
	input logic clk,
	input logic reset,
	input fp_multiplier_pkg::significand_t multiplicand,
	input fp_multiplier_pkg::significand_t multiplier,
	output fp_multiplier_pkg::product_t product
);
	import fp_multiplier_pkg::*;

	// Operands widened to the product width
	product_t wide_multiplicand;
	product_t wide_multiplier;

	// Unregistered product
	product_t full_product;

	// Zero extension, both inputs are unsigned
	assign wide_multiplicand = product_t'(multiplicand);
	assign wide_multiplier = product_t'(multiplier);

	// Full 64-bit product
	// Float multiply uses up to bit 47
	// Integer conversion can reach bit 54
	assign full_product = wide_multiplicand * wide_multiplier;

	// Kept in its own block so the wide multiply can be retimed
	// or swapped for a hard macro
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			product <= '0;
		else
			product <= full_product;
	end

endmodule

//--- fp_multiplier_normalize.sv
module fp_multiplier_normalize
(
	input logic clk,
	input logic reset,
	input fp_multiplier_pkg::mul_stage1_t stage1,
	input fp_multiplier_pkg::product_t product,
	output fp_multiplier_pkg::float_t result
);
	import fp_multiplier_pkg::*;

	// Product has no set bit
	logic product_zero;

	// Bit index of the leading one
	logic [5:0] lead_position;

	// Shift that moves the leading one to bit 63
	logic [5:0] shift_amount;

	// Product with the leading one at the top
	product_t aligned;

	// Exponent with two spare bits, signed so underflow shows
	logic signed [9:0] stage_exponent;
	logic signed [9:0] lead_offset;
	logic signed [9:0] adjusted_exponent;

	// Range checks on the adjusted exponent
	logic exponent_high;
	logic exponent_low;

	// Packed word before the output register
	float_t next_result;

	// Priority search for the leading one
	// Scanning upward, the highest set bit overwrites the others
	always_comb
	begin
		lead_position = 6'd0;
		for (int bit_index = 0; bit_index < 64; bit_index++)
		begin
			if (product[bit_index])
				lead_position = 6'(bit_index);
		end
	end

	assign product_zero = (product == '0);

	// Align so the hidden one lands on bit 63
	assign shift_amount = 6'd63 - lead_position;
	assign aligned = product << shift_amount;

	// Two normalized significands put the binary point at bit 46
	// The leading one position moves the exponent from there
	assign stage_exponent = $signed({2'b00, stage1.exponent});
	assign lead_offset = $signed({4'b0000, lead_position});
	assign adjusted_exponent = stage_exponent + lead_offset - 10'sd46;

	// 255 is reserved for infinity
	assign exponent_high = adjusted_exponent > 10'sd254;

	// Zero and below would be a denormal, flushed to zero
	assign exponent_low = adjusted_exponent < 10'sd1;

	// Result word
	always_comb
	begin
		// Sign survives every special case
		next_result.sign = stage1.sign;
		if (product_zero)
		begin
			// Zero operand or zero integer
			next_result.exponent = 8'd0;
			next_result.fraction = 23'd0;
		end
		else if (stage1.exponent_overflow || exponent_high)
		begin
			// Signed infinity
			next_result.exponent = 8'hff;
			next_result.fraction = 23'd0;
		end
		else if (exponent_low)
		begin
			// Underflow, flushed to signed zero
			next_result.exponent = 8'd0;
			next_result.fraction = 23'd0;
		end
		else
		begin
			next_result.exponent = adjusted_exponent[7:0];
			// 23 bits under the hidden one, the rest truncated
			next_result.fraction = aligned[62:40];
		end
	end

	// Output register, second pipeline edge
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			result <= '0;
		else
			result <= next_result;
	end

endmodule

//--- fp_multiplier.sv
module fp_multiplier
(
	input logic clk,
	input logic reset,
	input fp_multiplier_pkg::opcode_t operation,
	input fp_multiplier_pkg::float_t operand1,
	input fp_multiplier_pkg::float_t operand2,
	output fp_multiplier_pkg::float_t result
);
	import fp_multiplier_pkg::*;

	// Prepared significands, combinational from stage 1
	significand_t multiplicand;
	significand_t multiplier;

	// Registered sign, exponent and overflow
	mul_stage1_t stage1;

	// Registered significand product
	product_t product;

	// Exponent path
	// Also selects between multiply and integer conversion
	fp_multiplier_stage1 stage1_block
	(
		.clk(clk),
		.reset(reset),
		.operation(operation),
		.operand1(operand1),
		.operand2(operand2),
		.multiplicand(multiplicand),
		.multiplier(multiplier),
		.stage1(stage1)
	);

	// Significand multiply, side by side with the exponent register
	fp_significand_multiplier significand_block
	(
		.clk(clk),
		.reset(reset),
		.multiplicand(multiplicand),
		.multiplier(multiplier),
		.product(product)
	);

	// Second stage
	// Both registered halves arrive on the same edge
	fp_multiplier_normalize normalize_block
	(
		.clk(clk),
		.reset(reset),
		.stage1(stage1),
		.product(product),
		.result(result)
	);

endmodule

//--- fp_multiplier_tb.sv
module fp_multiplier_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import fp_multiplier_pkg::*;

	localparam int CLOCK_PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	// Upper bound on the directed operations over all tests
	localparam int DIRECTED_OPS = 40;
	localparam int STREAM_OPS = 200;
	localparam int TEST_COUNT = 6;
	// One idle drive plus two edges of pipeline latency
	localparam int DRAIN_CYCLES = 3;
	localparam int MARGIN_CYCLES = 50;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 + DIRECTED_OPS + STREAM_OPS
		+ TEST_COUNT * DRAIN_CYCLES + MARGIN_CYCLES;

	// DUT ports
	logic clk;
	logic reset;
	opcode_t operation;
	float_t operand1;
	float_t operand2;
	float_t result;

	// Operands on the inputs are to be checked
	logic issue;
	// Result must read zero around reset
	logic check_reset;

	// Expected results with one entry per pipeline edge
	float_t expected_pipe [0:1];
	logic valid_pipe [0:1];

	integer seed;
	int error_count = 0;
	int check_count = 0;
	int failed_tests;
	int test_total;
	int errors_at_start;
	int checks_at_start;
	string test_name;

	fp_multiplier uut
	(
		.clk(clk),
		.reset(reset),
		.operation(operation),
		.operand1(operand1),
		.operand2(operand2),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLOCK_PERIOD / 2) clk = ~clk;
	end

	// Expected result from the arithmetic rules
	function automatic float_t reference_result(input opcode_t op, input float_t a,
		input float_t b);
		logic res_sign;
		logic [7:0] exp_a;
		logic [7:0] exp_b;
		logic [7:0] unbiased_a;
		logic [7:0] unbiased_b;
		logic [7:0] unbiased_total;
		logic [7:0] stage_exp;
		logic overflow;
		logic [63:0] sig_a;
		logic [63:0] sig_b;
		logic [63:0] prod;
		logic [63:0] shifted;
		logic [31:0] raw;
		int lead;
		int new_exp;
		float_t r;
		raw = b;
		if (op == OP_ITOF)
		begin
			// First operand stands for exactly 1.0
			res_sign = raw[31];
			exp_a = 8'd127;
			exp_b = 8'd150;
			sig_a = 64'h80_0000;
			sig_b = raw[31] ? {32'd0, 32'd0 - raw} : {32'd0, raw};
		end
		else
		begin
			res_sign = a.sign ^ b.sign;
			exp_a = a.exponent;
			exp_b = b.exponent;
			// Zero exponent means a zero significand
			sig_a = (a.exponent == 8'd0) ? 64'd0 : {40'd0, 1'b1, a.fraction};
			sig_b = (b.exponent == 8'd0) ? 64'd0 : {40'd0, 1'b1, b.fraction};
		end
		// Unbiased exponents as 8-bit two's complement
		unbiased_a = exp_a - 8'd127;
		unbiased_b = exp_b - 8'd127;
		unbiased_total = unbiased_a + unbiased_b;
		overflow = (unbiased_a[7] == unbiased_b[7]) && (unbiased_total[7] != unbiased_a[7]);
		stage_exp = unbiased_total + 8'd127;
		prod = sig_a * sig_b;
		// Search down from the top for the leading one
		lead = 63;
		while (lead > 0 && prod[lead] == 1'b0)
			lead--;
		new_exp = int'(stage_exp) + lead - 46;
		// Leading one to bit 23 with the lower bits dropped
		if (lead >= 23)
			shifted = prod >> (lead - 23);
		else
			shifted = prod << (23 - lead);
		r.sign = res_sign;
		if (prod == 64'd0)
		begin
			r.exponent = 8'd0;
			r.fraction = 23'd0;
		end
		else if (overflow || new_exp > 254)
		begin
			r.exponent = 8'hff;
			r.fraction = 23'd0;
		end
		else if (new_exp < 1)
		begin
			r.exponent = 8'd0;
			r.fraction = 23'd0;
		end
		else
		begin
			r.exponent = new_exp[7:0];
			r.fraction = shifted[22:0];
		end
		return r;
	endfunction

	// Normal value with a moderate exponent and random fraction
	function automatic float_t random_normal();
		logic [31:0] value;
		float_t f;
		value = $random(seed);
		f.sign = value[31];
		f.exponent = 8'd100 + {2'b00, value[28:23]};
		f.fraction = value[22:0];
		return f;
	endfunction

	// Model runs on the operands the DUT samples at the same edge
	always @(posedge clk)
	begin
		if (reset)
		begin
			valid_pipe[0] <= 1'b0;
			valid_pipe[1] <= 1'b0;
		end
		else
		begin
			valid_pipe[0] <= issue;
			valid_pipe[1] <= valid_pipe[0];
		end
		expected_pipe[0] <= reference_result(operation, operand1, operand2);
		expected_pipe[1] <= expected_pipe[0];
	end

	// Count every check that an assertion makes at this edge
	always @(posedge clk)
	begin
		if (check_reset || valid_pipe[1])
			check_count++;
	end

	result_matches_model: assert property (@(posedge clk)
		valid_pipe[1] |-> result == expected_pipe[1])
	else
	begin
		$display("** Error: test %s expected %h actual %h", test_name,
			$sampled(expected_pipe[1]), $sampled(result));
		error_count++;
	end

	result_zero_in_reset: assert property (@(posedge clk) check_reset |-> result == '0)
	else
	begin
		$display("** Error: test %s expected %h actual %h", test_name, 32'h0,
			$sampled(result));
		error_count++;
	end

	// Drive one operation 2 ns after the next rising edge
	task automatic apply_operation(input opcode_t op, input float_t a, input float_t b);
		@(posedge clk);
		#2;
		operation = op;
		operand1 = a;
		operand2 = b;
		issue = 1'b1;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = error_count;
		checks_at_start = check_count;
	endtask

	// Stop issuing and let the last two results reach the checks
	task automatic drain_pipeline();
		@(posedge clk);
		#2;
		issue = 1'b0;
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic report_test();
		int errors;
		int checks;
		errors = error_count - errors_at_start;
		checks = check_count - checks_at_start;
		test_total++;
		if (errors != 0 || checks == 0)
			failed_tests++;
		$display("Test %-10s %0d checks, %0d errors", test_name, checks, errors);
	endtask

	initial
	begin
		logic [31:0] choice;
		seed = 37;
		failed_tests = 0;
		test_total = 0;
		test_name = "none";
		reset = 1'b1;
		issue = 1'b0;
		check_reset = 1'b0;
		// Non-zero operands so reset has something to hold back
		operation = OP_FMUL;
		operand1 = 32'h4000_0000;
		operand2 = 32'h4040_0000;

		// Reset held for 16 edges and then two edges of zero after release
		start_test("reset");
		for (int cycle = 0; cycle < RESET_CYCLES; cycle++)
		begin
			@(posedge clk);
			#2;
			if (cycle == 1)
				check_reset = 1'b1;
		end
		reset = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		check_reset = 1'b0;
		report_test();

		start_test("products");
		apply_operation(OP_FMUL, 32'h4000_0000, 32'h4040_0000);
		apply_operation(OP_FMUL, 32'hbfc0_0000, 32'h4080_0000);
		apply_operation(OP_FMUL, 32'hc000_0000, 32'hc040_0000);
		// Plus and minus 1.0 times random values
		for (int index = 0; index < 8; index++)
			apply_operation(OP_FMUL, index[0] ? 32'hbf80_0000 : 32'h3f80_0000, random_normal());
		drain_pipeline();
		report_test();

		// First operand is ignored so it carries junk
		start_test("itof");
		apply_operation(OP_ITOF, 32'h1234_5678, 32'd0);
		apply_operation(OP_ITOF, 32'h1234_5678, 32'd1);
		apply_operation(OP_ITOF, 32'h1234_5678, 32'hffff_ffff);
		apply_operation(OP_ITOF, 32'h1234_5678, 32'd12345);
		apply_operation(OP_ITOF, 32'h1234_5678, $random(seed));
		apply_operation(OP_ITOF, 32'h1234_5678, 32'h8000_0000);
		// More than 24 significant bits
		apply_operation(OP_ITOF, 32'h1234_5678, 32'h7fff_ffff);
		drain_pipeline();
		report_test();

		start_test("underflow");
		apply_operation(OP_FMUL, 32'h0000_0000, 32'h4040_0000);
		apply_operation(OP_FMUL, 32'h8000_0000, 32'h4040_0000);
		// Denormal input flushes to zero
		apply_operation(OP_FMUL, 32'h0000_0001, 32'h4000_0000);
		// Denormal next to 2^127 would give a normal value if it were not flushed
		apply_operation(OP_FMUL, 32'h0040_0000, 32'h7f00_0000);
		apply_operation(OP_FMUL, 32'h7f00_0000, 32'h8040_0000);
		// 2^-63 times 2^-64 lands at exponent zero
		apply_operation(OP_FMUL, 32'h2000_0000, 32'h1f80_0000);
		apply_operation(OP_FMUL, 32'ha000_0000, 32'h1f80_0000);
		// Same pair with 1.5 significands where the carry lifts it to exponent 1
		apply_operation(OP_FMUL, 32'h2040_0000, 32'h1fc0_0000);
		drain_pipeline();
		report_test();

		start_test("overflow");
		// 2^100 squared wraps the exponent sum
		apply_operation(OP_FMUL, 32'h7180_0000, 32'h7180_0000);
		apply_operation(OP_FMUL, 32'hf180_0000, 32'h7180_0000);
		// 1.5 * 2^64 times 1.5 * 2^63 carries past 254
		apply_operation(OP_FMUL, 32'h5fc0_0000, 32'h5f40_0000);
		apply_operation(OP_FMUL, 32'hdfc0_0000, 32'h5f40_0000);
		drain_pipeline();
		report_test();

		// One operation per cycle with mixed opcodes
		start_test("stream");
		for (int index = 0; index < STREAM_OPS; index++)
		begin
			choice = $random(seed);
			if (choice[0])
				apply_operation(OP_ITOF, random_normal(), $random(seed));
			else if (choice[1] && choice[2])
				apply_operation(OP_FMUL, $random(seed), $random(seed));
			else
				apply_operation(OP_FMUL, random_normal(), random_normal());
		end
		drain_pipeline();
		report_test();

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			test_total, failed_tests, check_count, error_count);
		if (error_count == 0 && failed_tests == 0 && check_count > 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Ends a run that stops making progress
	initial
	begin
		#(WATCHDOG_CYCLES * CLOCK_PERIOD);
		$display("Watchdog timeout, the tests did not finish within %0d cycles",
			WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$finish;
	end

endmodule

//--- compile.f
fp_multiplier_pkg.sv
fp_multiplier_stage1.sv
fp_significand_multiplier.sv
fp_multiplier_normalize.sv
fp_multiplier.sv
fp_multiplier_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module fp_multiplier_tb -f compile.f \
	-o fp_multiplier_sim || { echo "Build failed"; exit 1; }
sim_output=$(./obj_dir/fp_multiplier_sim)
echo "$sim_output"
# Status follows the pass line in the simulation output
echo "$sim_output" | grep -q "^Result: PASSED$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
